/* source/cpu_pkg.sv */
package cpu_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// major opcodes, instruction bits 30:25
	localparam logic [5:0] OPC_ALU1 = 6'b100000;
	localparam logic [5:0] OPC_ADDI = 6'b101000;
	localparam logic [5:0] OPC_ORI  = 6'b101100;
	localparam logic [5:0] OPC_MOVI = 6'b100010;
	localparam logic [5:0] OPC_LWI  = 6'b000010;
	localparam logic [5:0] OPC_SWI  = 6'b001010;
	localparam logic [5:0] OPC_BR1  = 6'b100110;
	localparam logic [5:0] OPC_J    = 6'b100100;

	// register-form sub-ops, also the alu operation code
	localparam logic [4:0] SUB_ADD = 5'b00000;
	localparam logic [4:0] SUB_SUB = 5'b00001;
	localparam logic [4:0] SUB_AND = 5'b00010;
	localparam logic [4:0] SUB_XOR = 5'b00011;
	localparam logic [4:0] SUB_OR  = 5'b00100;
	localparam logic [4:0] SUB_SLT = 5'b00110;

	typedef struct packed {
		logic              fmt;
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [4:0]        rsv;
		logic [4:0]        sub;
	} instr_r_t;

	// bsense selects bne over beq, and is imm15 bit 14 elsewhere
	typedef struct packed {
		logic              fmt;
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] ra;
		logic              bsense;
		logic [13:0]       imm14;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// opcode 0 decodes to nothing, so this is a bubble
	localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0000;

endpackage

/* source/ex_if.sv */
`timescale 1ns/1ns

interface ex_if import cpu_pkg::*; ();

	logic              valid;
	logic [4:0]        alu_op;
	logic [XLEN-1:0]   operand_a;
	logic [XLEN-1:0]   operand_b;
	logic [XLEN-1:0]   store_data;
	logic [REG_AW-1:0] dest;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic [XLEN-1:0]   ex_result;

	modport ctrl (output valid, alu_op, operand_a, operand_b, store_data, dest,
		reg_write, mem_read, mem_write);
	modport exec (input valid, alu_op, operand_a, operand_b, store_data, dest,
		reg_write, mem_read, mem_write, output ex_result);
	modport fwd (input valid, dest, reg_write, mem_read, ex_result);

endinterface

/* source/mem_if.sv */
`timescale 1ns/1ns

interface mem_if import cpu_pkg::*; ();

	logic              valid;
	logic [XLEN-1:0]   result;
	logic [XLEN-1:0]   store_data;
	logic [REG_AW-1:0] dest;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic              overflow;
	// load data or alu result, picked in the memory stage
	logic [XLEN-1:0]   mem_result;

	modport exec (output valid, result, store_data, dest, reg_write, mem_read,
		mem_write, overflow);
	modport mem (input valid, result, store_data, dest, reg_write, mem_read,
		mem_write, output mem_result);
	modport fwd (input valid, dest, reg_write, mem_result);

endinterface

/* source/pc.sv */
`timescale 1ns/1ns

module pc import cpu_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            enable_system,
	input  logic            stall,
	input  logic            take_branch,
	input  logic [XLEN-1:0] branch_target,
	input  logic [XLEN-1:0] IM_out,
	output logic [XLEN-1:0] IM_address,
	output logic [XLEN-1:0] if_instr,
	output logic [XLEN-1:0] if_pc
);

	logic [XLEN-1:0] pc_q;

	assign IM_address = pc_q;

	// a taken branch flushes the wrong-path fetch
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc_q     <= RESET_PC;
			if_instr <= NOP_WORD;
		end else if (enable_system && !stall) begin
			if (take_branch) begin
				pc_q     <= branch_target;
				if_instr <= NOP_WORD;
			end else begin
				pc_q     <= pc_q + 32'd4;
				if_instr <= IM_out;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enable_system && !stall) begin
			if_pc <= pc_q;
		end
	end

endmodule

/* source/controller.sv */
`timescale 1ns/1ns

module controller import cpu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              enable_system,
	input  logic              stall,
	input  logic [XLEN-1:0]   if_instr,
	input  logic [XLEN-1:0]   if_pc,
	input  logic [XLEN-1:0]   fwd_ra,
	input  logic [XLEN-1:0]   fwd_rb,
	input  logic [XLEN-1:0]   fwd_rt,
	output logic [REG_AW-1:0] ra_addr,
	output logic [REG_AW-1:0] rb_addr,
	output logic [REG_AW-1:0] rt_addr,
	output logic              take_branch,
	output logic [XLEN-1:0]   branch_target,
	ex_if.ctrl                ex
);

	instr_u          ins;
	logic [14:0]     imm15;
	logic [23:0]     imm24;
	logic [XLEN-1:0] imm;
	logic [4:0]      dec_op;
	logic            dec_valid;
	logic            dec_reg_write;
	logic            dec_mem_read;
	logic            dec_mem_write;
	logic            use_imm;
	logic            zero_a;
	logic            is_branch;
	logic            is_jump;

	assign ins     = if_instr;
	assign ra_addr = ins.r.ra;
	assign rb_addr = ins.r.rb;
	assign rt_addr = ins.r.rt;
	assign imm15   = {ins.i.bsense, ins.i.imm14};
	assign imm24   = {ins.i.rt[3:0], ins.i.ra, ins.i.bsense, ins.i.imm14};

	always_comb begin
		dec_op        = SUB_ADD;
		dec_valid     = 1'b1;
		dec_reg_write = 1'b0;
		dec_mem_read  = 1'b0;
		dec_mem_write = 1'b0;
		use_imm       = 1'b1;
		zero_a        = 1'b0;
		is_branch     = 1'b0;
		is_jump       = 1'b0;
		imm           = {{17{imm15[14]}}, imm15};
		case (ins.r.opcode)
			OPC_ALU1: begin
				dec_op        = ins.r.sub;
				dec_reg_write = 1'b1;
				use_imm       = 1'b0;
			end
			OPC_ADDI: dec_reg_write = 1'b1;
			OPC_ORI: begin
				dec_op        = SUB_OR;
				dec_reg_write = 1'b1;
				imm           = {17'b0, imm15};
			end
			OPC_MOVI: begin
				dec_reg_write = 1'b1;
				zero_a        = 1'b1;
				imm           = {{12{ins.i.ra[4]}}, ins.i.ra, ins.i.bsense, ins.i.imm14};
			end
			// word-scaled offsets
			OPC_LWI: begin
				dec_reg_write = 1'b1;
				dec_mem_read  = 1'b1;
				imm           = {{15{imm15[14]}}, imm15, 2'b00};
			end
			OPC_SWI: begin
				dec_mem_write = 1'b1;
				imm           = {{15{imm15[14]}}, imm15, 2'b00};
			end
			OPC_BR1: is_branch = 1'b1;
			OPC_J: is_jump = 1'b1;
			default: dec_valid = 1'b0;
		endcase
	end

	// halfword offsets, relative to the branch itself
	assign branch_target = if_pc + (is_jump ? {{7{imm24[23]}}, imm24, 1'b0}
		: {{17{ins.i.imm14[13]}}, ins.i.imm14, 1'b0});
	// no decision while the operands are still in flight
	assign take_branch = !stall && (is_jump ||
		(is_branch && ((fwd_rt == fwd_ra) != ins.i.bsense)));

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ex.valid     <= 1'b0;
			ex.reg_write <= 1'b0;
			ex.mem_read  <= 1'b0;
			ex.mem_write <= 1'b0;
		end else if (enable_system) begin
			ex.valid     <= dec_valid && !stall;
			ex.reg_write <= dec_reg_write && !stall;
			ex.mem_read  <= dec_mem_read && !stall;
			ex.mem_write <= dec_mem_write && !stall;
		end
	end

	always_ff @(posedge clock) begin
		if (enable_system) begin
			ex.alu_op     <= dec_op;
			ex.operand_a  <= zero_a ? '0 : fwd_ra;
			ex.operand_b  <= use_imm ? imm : fwd_rb;
			ex.store_data <= fwd_rt;
			ex.dest       <= ins.r.rt;
		end
	end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ns

module regfile import cpu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              enable_system,
	input  logic [REG_AW-1:0] ra_addr,
	input  logic [REG_AW-1:0] rb_addr,
	input  logic [REG_AW-1:0] rt_addr,
	input  logic              wb_write,
	input  logic [REG_AW-1:0] wb_addr,
	input  logic [XLEN-1:0]   wb_data,
	output logic [XLEN-1:0]   ra_data,
	output logic [XLEN-1:0]   rb_data,
	output logic [XLEN-1:0]   rt_data
);

	logic [XLEN-1:0] regs [2**REG_AW];

	// same-cycle write shows up on the read
	function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
		if (wb_write && wb_addr == addr) begin
			return wb_data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (enable_system && wb_write) begin
			regs[wb_addr] <= wb_data;
		end
	end

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

/* source/forward.sv */
`timescale 1ns/1ns

module forward import cpu_pkg::*; (
	input  logic [REG_AW-1:0] ra_addr,
	input  logic [REG_AW-1:0] rb_addr,
	input  logic [REG_AW-1:0] rt_addr,
	input  logic [XLEN-1:0]   ra_data,
	input  logic [XLEN-1:0]   rb_data,
	input  logic [XLEN-1:0]   rt_data,
	ex_if.fwd                 ex,
	mem_if.fwd                mem,
	input  logic              wb_write,
	input  logic [REG_AW-1:0] wb_addr,
	input  logic [XLEN-1:0]   wb_data,
	output logic [XLEN-1:0]   fwd_ra,
	output logic [XLEN-1:0]   fwd_rb,
	output logic [XLEN-1:0]   fwd_rt,
	output logic              stall
);

	// youngest writer wins
	function automatic logic [XLEN-1:0] bypass(
		input logic [REG_AW-1:0] addr,
		input logic [XLEN-1:0]   raw
	);
		if (ex.valid && ex.reg_write && ex.dest == addr) begin
			return ex.ex_result;
		end
		if (mem.valid && mem.reg_write && mem.dest == addr) begin
			return mem.mem_result;
		end
		if (wb_write && wb_addr == addr) begin
			return wb_data;
		end
		return raw;
	endfunction

	always_comb begin
		fwd_ra = bypass(ra_addr, ra_data);
		fwd_rb = bypass(rb_addr, rb_data);
		fwd_rt = bypass(rt_addr, rt_data);
	end

	// load data not ready until the memory stage
	assign stall = ex.valid && ex.mem_read &&
		(ex.dest == ra_addr || ex.dest == rb_addr || ex.dest == rt_addr);

endmodule

/* source/alu.sv */
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
	input  logic clock,
	input  logic rst_n,
	input  logic enable_system,
	ex_if.exec   ex,
	mem_if.exec  mem,
	output logic alu_overflow
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic [XLEN-1:0] result;
	logic            ovf;

	assign sum  = ex.operand_a + ex.operand_b;
	assign diff = ex.operand_a - ex.operand_b;

	always_comb begin
		ovf = 1'b0;
		case (ex.alu_op)
			SUB_ADD: begin
				result = sum;
				ovf    = (ex.operand_a[XLEN-1] == ex.operand_b[XLEN-1]) &&
					(sum[XLEN-1] != ex.operand_a[XLEN-1]);
			end
			SUB_SUB: begin
				result = diff;
				ovf    = (ex.operand_a[XLEN-1] != ex.operand_b[XLEN-1]) &&
					(diff[XLEN-1] != ex.operand_a[XLEN-1]);
			end
			SUB_AND: result = ex.operand_a & ex.operand_b;
			SUB_OR:  result = ex.operand_a | ex.operand_b;
			SUB_XOR: result = ex.operand_a ^ ex.operand_b;
			SUB_SLT: result = {31'b0, $signed(ex.operand_a) < $signed(ex.operand_b)};
			default: result = '0;
		endcase
	end

	assign ex.ex_result = result;

	// address arithmetic never flags overflow
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mem.valid     <= 1'b0;
			mem.reg_write <= 1'b0;
			mem.mem_read  <= 1'b0;
			mem.mem_write <= 1'b0;
			mem.overflow  <= 1'b0;
		end else if (enable_system) begin
			mem.valid     <= ex.valid;
			mem.reg_write <= ex.reg_write;
			mem.mem_read  <= ex.mem_read;
			mem.mem_write <= ex.mem_write;
			mem.overflow  <= ex.valid && ovf && !ex.mem_read && !ex.mem_write;
		end
	end

	always_ff @(posedge clock) begin
		if (enable_system) begin
			mem.result     <= result;
			mem.store_data <= ex.store_data;
			mem.dest       <= ex.dest;
		end
	end

	assign alu_overflow = mem.overflow;

endmodule

/* source/memstage.sv */
`timescale 1ns/1ns

module memstage import cpu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              enable_system,
	mem_if.mem                mem,
	input  logic [XLEN-1:0]   DM_out,
	output logic              DM_enable,
	output logic              DM_read,
	output logic              DM_write,
	output logic [XLEN-1:0]   DM_address,
	output logic [XLEN-1:0]   DM_in,
	output logic              wb_write,
	output logic [REG_AW-1:0] wb_addr,
	output logic [XLEN-1:0]   wb_data
);

	assign DM_read    = mem.valid && mem.mem_read;
	assign DM_write   = mem.valid && mem.mem_write;
	assign DM_enable  = DM_read || DM_write;
	assign DM_address = mem.result;
	assign DM_in      = mem.store_data;

	// memory answers in the same cycle
	assign mem.mem_result = mem.mem_read ? DM_out : mem.result;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb_write <= 1'b0;
		end else if (enable_system) begin
			wb_write <= mem.valid && mem.reg_write;
		end
	end

	always_ff @(posedge clock) begin
		if (enable_system) begin
			wb_addr <= mem.dest;
			wb_data <= mem.mem_result;
		end
	end

endmodule

/* source/cpu.sv */
`timescale 1ns/1ns

module cpu import cpu_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            do_system,
	output logic [XLEN-1:0] IM_address,
	input  logic [XLEN-1:0] IM_out,
	output logic            DM_enable,
	output logic            DM_read,
	output logic            DM_write,
	output logic [XLEN-1:0] DM_address,
	output logic [XLEN-1:0] DM_in,
	input  logic [XLEN-1:0] DM_out,
	output logic            alu_overflow
);

	logic [XLEN-1:0]   if_instr;
	logic [XLEN-1:0]   if_pc;
	logic              take_branch;
	logic [XLEN-1:0]   branch_target;
	logic              stall;

	logic [REG_AW-1:0] ra_addr;
	logic [REG_AW-1:0] rb_addr;
	logic [REG_AW-1:0] rt_addr;
	logic [XLEN-1:0]   ra_data;
	logic [XLEN-1:0]   rb_data;
	logic [XLEN-1:0]   rt_data;
	logic [XLEN-1:0]   fwd_ra;
	logic [XLEN-1:0]   fwd_rb;
	logic [XLEN-1:0]   fwd_rt;

	logic              wb_write;
	logic [REG_AW-1:0] wb_addr;
	logic [XLEN-1:0]   wb_data;

	ex_if  ex_bus ();
	mem_if mem_bus ();

	pc #(.RESET_PC(RESET_PC)) u_pc (
		.clock, .rst_n, .enable_system(do_system), .stall, .take_branch,
		.branch_target, .IM_out, .IM_address, .if_instr, .if_pc
	);

	controller u_controller (
		.clock, .rst_n, .enable_system(do_system), .stall, .if_instr, .if_pc,
		.fwd_ra, .fwd_rb, .fwd_rt, .ra_addr, .rb_addr, .rt_addr,
		.take_branch, .branch_target, .ex(ex_bus)
	);

	regfile u_regfile (
		.clock, .rst_n, .enable_system(do_system), .ra_addr, .rb_addr, .rt_addr,
		.wb_write, .wb_addr, .wb_data, .ra_data, .rb_data, .rt_data
	);

	forward u_forward (
		.ra_addr, .rb_addr, .rt_addr, .ra_data, .rb_data, .rt_data,
		.ex(ex_bus), .mem(mem_bus), .wb_write, .wb_addr, .wb_data,
		.fwd_ra, .fwd_rb, .fwd_rt, .stall
	);

	alu u_alu (
		.clock, .rst_n, .enable_system(do_system), .ex(ex_bus), .mem(mem_bus),
		.alu_overflow
	);

	memstage u_memstage (
		.clock, .rst_n, .enable_system(do_system), .mem(mem_bus), .DM_out,
		.DM_enable, .DM_read, .DM_write, .DM_address, .DM_in,
		.wb_write, .wb_addr, .wb_data
	);

endmodule

/* tb/cpu_props.sv */
`timescale 1ns/1ns

module cpu_props #(
	parameter logic [31:0] RESET_PC    = '0,
	parameter logic [31:0] MARK_ADDR   = 32'h0000_03f0,
	parameter logic [31:0] POISON_ADDR = 32'h0000_03e0
) (
	input logic        clock,
	input logic        rst_n,
	input logic        do_system,
	input logic [31:0] IM_address,
	input logic        DM_enable,
	input logic        DM_read,
	input logic        DM_write,
	input logic [31:0] DM_address,
	input logic        alu_overflow
);

	int unsigned prop_errors = 0;

	// values still sampled from the reset state on the release edge
	reset_state: assert property (@(posedge clock) $rose(rst_n) |->
		!DM_enable && !DM_read && !DM_write && !alu_overflow && IM_address == RESET_PC)
	else begin
		prop_errors++;
		$error("outputs were not in their reset state when reset was released");
	end

	one_access: assert property (@(posedge clock) disable iff (!rst_n)
		DM_enable |-> !(DM_read && DM_write))
	else begin
		prop_errors++;
		$error("data port asked for a read and a write at once");
	end

	// overflowing add sits right before the store to the marker
	overflow_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		alu_overflow |=> !alu_overflow && DM_write && DM_address == MARK_ADDR)
	else begin
		prop_errors++;
		$error("overflow flag was not a single cycle ahead of the marker store");
	end

	marker_after_overflow: assert property (@(posedge clock) disable iff (!rst_n)
		DM_write && DM_address == MARK_ADDR |-> $past(alu_overflow))
	else begin
		prop_errors++;
		$error("marker store arrived without the overflow flag before it");
	end

	no_wrong_path: assert property (@(posedge clock) disable iff (!rst_n)
		!(DM_write && DM_address == POISON_ADDR))
	else begin
		prop_errors++;
		$error("a store from a skipped instruction reached the data port");
	end

	freeze_hold: assert property (@(posedge clock) disable iff (!rst_n)
		!do_system |=> $stable(IM_address) && $stable(DM_enable) && $stable(DM_address))
	else begin
		prop_errors++;
		$error("fetch address or data port moved while the core was frozen");
	end

endmodule

bind cpu cpu_props #(.RESET_PC(RESET_PC)) u_props (
	.clock(clock),
	.rst_n(rst_n),
	.do_system(do_system),
	.IM_address(IM_address),
	.DM_enable(DM_enable),
	.DM_read(DM_read),
	.DM_write(DM_write),
	.DM_address(DM_address),
	.alu_overflow(alu_overflow)
);

/* tb/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

	localparam int          PERIOD        = 40;
	localparam int          PROG_MAX      = 256;
	localparam int          FREEZE_CYCLES = 6;
	localparam logic [14:0] MARK_WORD     = 15'h0fc;
	localparam logic [14:0] POISON_WORD   = 15'h0f8;

	logic            clock;
	logic            rst_n;
	logic            do_system;
	logic [XLEN-1:0] IM_address;
	logic [XLEN-1:0] IM_out;
	logic            DM_enable;
	logic            DM_read;
	logic            DM_write;
	logic [XLEN-1:0] DM_address;
	logic [XLEN-1:0] DM_in;
	logic [XLEN-1:0] DM_out;
	logic            alu_overflow;

	logic [31:0] prog [PROG_MAX];
	logic [31:0] dm [256];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] lfsr_state;
	int          prog_len;
	int          slot;
	int          store_idx;
	int          tb_errors;

	cpu uut (
		.clock, .rst_n, .do_system, .IM_address, .IM_out, .DM_enable, .DM_read,
		.DM_write, .DM_address, .DM_in, .DM_out, .alu_overflow
	);

	// past the program the fetch sees bubbles
	assign IM_out = (IM_address < 32'(PROG_MAX * 4)) ? prog[IM_address[9:2]] : NOP_WORD;
	assign DM_out = dm[DM_address[9:2]];

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] rnd(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] fill_value(input int a);
		return (32'(a) * 32'h0001_0003) ^ 32'h0000_5a5a;
	endfunction

	function automatic logic [31:0] sext15(input logic [14:0] x);
		return {{17{x[14]}}, x};
	endfunction

	function automatic logic [31:0] reg_op(input logic [4:0] sub, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, OPC_ALU1, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic logic [31:0] imm_op(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, opc, rt, ra, imm};
	endfunction

	function automatic logic [31:0] movi_op(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, OPC_MOVI, rt, imm};
	endfunction

	function automatic logic [31:0] branch_op(input logic bne, input logic [4:0] rt,
		input logic [4:0] ra, input logic [13:0] off);
		return {1'b0, OPC_BR1, rt, ra, bne, off};
	endfunction

	function automatic logic [31:0] jump_op(input logic [23:0] off);
		return {1'b0, OPC_J, 1'b0, off};
	endfunction

	// word offsets 64 and up hold the checked stores
	function automatic logic [14:0] store_slot();
		slot++;
		return 15'(63 + slot);
	endfunction

	function automatic logic [31:0] alu_ref(input logic [4:0] op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			SUB_ADD: return a + b;
			SUB_SUB: return a - b;
			SUB_AND: return a & b;
			SUB_OR:  return a | b;
			SUB_XOR: return a ^ b;
			SUB_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic build_program();
		logic [4:0]  ops [6];
		logic [4:0]  dst;
		logic [4:0]  last;
		logic [4:0]  prev;
		logic [19:0] v;
		ops  = '{SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR, SUB_SLT};
		last = 5'd3;
		prev = 5'd2;
		emit(movi_op(5'd1, 20'(rnd(12))));
		emit(imm_op(OPC_ADDI, 5'd2, 5'd1, 15'(rnd(10))));
		emit(imm_op(OPC_ORI, 5'd3, 5'd2, 15'(rnd(10))));
		emit(imm_op(OPC_SWI, 5'd3, 5'd0, store_slot()));
		for (int k = 0; k < 6; k++) begin
			dst = 5'(4 + k % 3);
			emit(reg_op(ops[k], dst, last, prev));
			emit(imm_op(OPC_SWI, dst, 5'd0, store_slot()));
			prev = last;
			last = dst;
		end
		// load-use pair
		emit(imm_op(OPC_LWI, 5'd10, 5'd0, 15'(rnd(5))));
		emit(reg_op(SUB_ADD, 5'd11, 5'd10, 5'd1));
		emit(imm_op(OPC_SWI, 5'd11, 5'd0, store_slot()));
		// beq taken, bne not taken, j, each offset skips one word
		v = 20'(rnd(8));
		emit(movi_op(5'd12, v));
		emit(movi_op(5'd13, v));
		emit(branch_op(1'b0, 5'd12, 5'd13, 14'd4));
		emit(imm_op(OPC_SWI, 5'd12, 5'd0, POISON_WORD));
		emit(imm_op(OPC_SWI, 5'd12, 5'd0, store_slot()));
		emit(branch_op(1'b1, 5'd12, 5'd13, 14'd4));
		emit(imm_op(OPC_SWI, 5'd13, 5'd0, store_slot()));
		emit(jump_op(24'd4));
		emit(imm_op(OPC_SWI, 5'd13, 5'd0, POISON_WORD));
		emit(imm_op(OPC_SWI, 5'd13, 5'd0, store_slot()));
		// double 2**18 up to 2**30, then one add past the sign bit
		emit(movi_op(5'd7, 20'h40000));
		for (int k = 0; k < 12; k++) begin
			emit(reg_op(SUB_ADD, 5'd7, 5'd7, 5'd7));
		end
		emit(reg_op(SUB_ADD, 5'd9, 5'd7, 5'd7));
		emit(imm_op(OPC_SWI, 5'd9, 5'd0, MARK_WORD));
	endtask

	// instruction-level model, one instruction per step
	task automatic run_model();
		logic [31:0] r [32];
		logic [31:0] mem [256];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] ins;
		logic [31:0] addr;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_value(i);
		end
		pc    = '0;
		steps = 0;
		while (pc < 32'(prog_len * 4) && steps < 1000) begin
			ins  = prog[pc[9:2]];
			rt   = ins[24:20];
			ra   = ins[19:15];
			rb   = ins[14:10];
			npc  = pc + 32'd4;
			addr = r[ra] + (sext15(ins[14:0]) << 2);
			case (ins[30:25])
				OPC_ALU1: r[rt] = alu_ref(ins[4:0], r[ra], r[rb]);
				OPC_ADDI: r[rt] = r[ra] + sext15(ins[14:0]);
				OPC_ORI:  r[rt] = r[ra] | {17'b0, ins[14:0]};
				OPC_MOVI: r[rt] = {{12{ins[19]}}, ins[19:0]};
				OPC_LWI:  r[rt] = mem[addr[9:2]];
				OPC_SWI: begin
					mem[addr[9:2]] = r[rt];
					exp_addr.push_back(addr);
					exp_data.push_back(r[rt]);
				end
				OPC_BR1: begin
					if ((r[rt] == r[ra]) != ins[14]) begin
						npc = pc + {{17{ins[13]}}, ins[13:0], 1'b0};
					end
				end
				OPC_J: npc = pc + {{7{ins[23]}}, ins[23:0], 1'b0};
				default: ;
			endcase
			pc = npc;
			steps++;
		end
	endtask

	task automatic watchdog();
		int limit;
		limit = (prog_len * 4 + FREEZE_CYCLES + 4) * PERIOD;
		#(limit);
		$display("timeout after %0d ns, only %0d of %0d stores seen", limit, store_idx,
			exp_addr.size());
		$display("Test failed");
		$finish;
	endtask

	// stores only count on edges where the core advances
	always @(posedge clock) begin
		if (rst_n && do_system && DM_write) begin
			assert (store_idx < exp_addr.size()) else begin
				tb_errors++;
				$display("unexpected extra store to %h at %0t ns", DM_address, $time);
			end
			if (store_idx < exp_addr.size()) begin
				assert (DM_address == exp_addr[store_idx]) else begin
					tb_errors++;
					$display("FAIL %0t: store %0d address %h, expected %h", $time,
						store_idx, DM_address, exp_addr[store_idx]);
				end
				assert (DM_in == exp_data[store_idx]) else begin
					tb_errors++;
					$display("FAIL %0t: store %0d data %h, expected %h", $time,
						store_idx, DM_in, exp_data[store_idx]);
				end
			end
			dm[DM_address[9:2]] <= DM_in;
			store_idx++;
		end
	end

	initial begin
		int unsigned prop_errs;
		rst_n      = 1'b0;
		do_system  = 1'b1;
		tb_errors  = 0;
		store_idx  = 0;
		slot       = 0;
		prog_len   = 0;
		lfsr_state = 32'h5b98;
		for (int a = 0; a < 256; a++) begin
			dm[a]   = fill_value(a);
			prog[a] = NOP_WORD;
		end
		build_program();
		run_model();
		fork
			watchdog();
		join_none
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		// freeze in the middle of the dependent ALU chain
		wait (store_idx >= 4);
		@(negedge clock);
		do_system = 1'b0;
		repeat (FREEZE_CYCLES) @(negedge clock);
		do_system = 1'b1;
		wait (store_idx >= exp_addr.size());
		repeat (8) @(negedge clock);
		prop_errs = uut.u_props.prop_errors;
		$display("errors: %0d store checks, %0d properties", tb_errors, prop_errs);
		if (tb_errors == 0 && prop_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* files.f */
source/cpu_pkg.sv
source/ex_if.sv
source/mem_if.sv
source/pc.sv
source/controller.sv
source/regfile.sv
source/forward.sv
source/alu.sv
source/memstage.sv
source/cpu.sv
tb/cpu_props.sv
tb/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - files:
      - source/cpu_pkg.sv
      - source/ex_if.sv
      - source/mem_if.sv
      - source/pc.sv
      - source/controller.sv
      - source/regfile.sv
      - source/forward.sv
      - source/alu.sv
      - source/memstage.sv
      - source/cpu.sv
  - target: test
    files:
      - tb/cpu_props.sv
      - tb/cpu_tb.sv
